// ==== design/address_decoder.sv ====
`timescale 1ns/1ps
`include "mmio_settings.svh"

module address_decoder (
    input  logic [`ADDR_WIDTH-1:0]              addr,
    output mmio_pkg::region_e                   region,
    output logic [$clog2(`RAM_WORDS)-1:0]       ram_index,
    output logic [$clog2(`SD_SECTOR_BYTES)-1:0] buf_index
);
    import mmio_pkg::*;

    logic [`ADDR_WIDTH-1:0] ram_offset;
    logic [`ADDR_WIDTH-1:0] buf_offset;
    logic                   in_ram;
    logic                   in_buf;

    // offsets from each window base
    // addresses below a base wrap high and fail the span test
    assign ram_offset = addr - `RAM_BASE;
    assign buf_offset = addr - `SD_BUF_BASE;
    assign in_ram     = ram_offset < (`RAM_WORDS * 4);
    assign in_buf     = buf_offset < `SD_SECTOR_BYTES;

    // word index drops the byte offset bits
    assign ram_index = ram_offset[$clog2(`RAM_WORDS)+1:2];
    assign buf_index = buf_offset[$clog2(`SD_SECTOR_BYTES)-1:0];

    always_comb begin
        // ram wins over everything else
        if (in_ram) begin
            region = REGION_RAM;
        end else if (in_buf) begin
            region = REGION_SD_BUF;
        end else begin
            case (addr)
                `KEY_ADDR:     region = REGION_KEY;
                `SD_ADDR_REG:  region = REGION_SD_ADDR;
                `SD_READ_REG:  region = REGION_SD_READ;
                `SD_READY_REG: region = REGION_SD_READY;
                `SD_AVAIL_REG: region = REGION_SD_AVAIL;
                // unmapped, completes with zero data
                default:       region = REGION_NONE;
            endcase
        end
    end

endmodule

// ==== design/bus_sequencer.sv ====
`timescale 1ns/1ps
`include "mmio_settings.svh"

module bus_sequencer (
    input  logic                   CLOCK_50,
    input  logic                   KEY0,
    input  mmio_pkg::bus_req_t     bus_req,
    input  logic                   read_enable,
    input  logic                   write_enable,
    input  mmio_pkg::region_e      region,
    input  logic [`WORD_WIDTH-1:0] ram_word,
    input  logic [7:0]             key_code,
    input  logic                   sd_ready,
    input  logic                   sd_available,
    input  logic [7:0]             buf_byte,
    output logic [`DATA_WIDTH-1:0] read_data,
    output logic                   read_done,
    output logic                   write_done,
    output logic                   ram_write,
    output logic                   ram_hi_word,
    output mmio_pkg::region_e      reg_write,
    output logic                   reg_write_en
);
    import mmio_pkg::*;

    seq_state_e             state;
    // first cycle of ST_READ/ST_WRITE waits for the registered ram word
    logic                   step;
    logic                   ram_double;
    logic [`WORD_WIDTH-1:0] ram_shifted;
    logic [`WORD_WIDTH-1:0] lo_word;
    logic [`DATA_WIDTH-1:0] read_mux;

    // only ram accesses take the second word step
    assign ram_double = (region == REGION_RAM) && (bus_req.ls_type == LS_D);

    // sub-word loads come back shifted down by the byte offset
    assign ram_shifted = ram_word >> {bus_req.addr[1:0], 3'b000};

    // ram stores on the second cycle of ST_WRITE and again in ST_WRITE_HI
    assign ram_write = (region == REGION_RAM) &&
                       (((state == ST_WRITE) && step) || (state == ST_WRITE_HI));

    // point the ram at the next word one cycle early for a double read
    assign ram_hi_word = ((state == ST_READ) && step && ram_double) ||
                         (state == ST_READ_HI) || (state == ST_WRITE_HI);

    // register writes land on the same edge that raises write_done
    assign reg_write_en = (state == ST_WRITE) && step && (region != REGION_RAM);
    assign reg_write    = reg_write_en ? region : REGION_NONE;

    // read source per region, zero-extended
    always_comb begin
        read_mux = '0;
        case (region)
            REGION_RAM:      read_mux[`WORD_WIDTH-1:0] = ram_shifted;
            REGION_KEY:      read_mux[7:0] = key_code;
            REGION_SD_READY: read_mux[0] = sd_ready;
            REGION_SD_AVAIL: read_mux[0] = sd_available;
            REGION_SD_BUF:   read_mux[7:0] = buf_byte;
            default:         read_mux = '0;
        endcase
    end

    always_ff @(posedge CLOCK_50 or negedge KEY0) begin
        if (!KEY0) begin
            state      <= ST_IDLE;
            step       <= 1'b0;
            read_done  <= 1'b1;
            write_done <= 1'b1;
            read_data  <= '0;
        end else begin
            case (state)
                ST_IDLE: begin
                    step <= 1'b0;
                    // done drops on the edge that sees the strobe
                    if (read_enable) begin
                        read_done <= 1'b0;
                        state     <= ST_READ;
                    end else if (write_enable) begin
                        write_done <= 1'b0;
                        state      <= ST_WRITE;
                    end
                end
                ST_READ: begin
                    step <= 1'b1;
                    if (step) begin
                        step <= 1'b0;
                        if (ram_double) begin
                            state <= ST_READ_HI;
                        end else begin
                            read_data <= read_mux;
                            read_done <= 1'b1;
                            state     <= ST_IDLE;
                        end
                    end
                end
                ST_READ_HI: begin
                    // upper word at address + 4
                    read_data <= {ram_word, lo_word};
                    read_done <= 1'b1;
                    state     <= ST_IDLE;
                end
                ST_WRITE: begin
                    step <= 1'b1;
                    if (step) begin
                        step <= 1'b0;
                        if (ram_double) begin
                            state <= ST_WRITE_HI;
                        end else begin
                            write_done <= 1'b1;
                            state      <= ST_IDLE;
                        end
                    end
                end
                ST_WRITE_HI: begin
                    write_done <= 1'b1;
                    state      <= ST_IDLE;
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

    // low half of a doubleword, held until the upper word arrives
    always_ff @(posedge CLOCK_50) begin
        if ((state == ST_READ) && step && ram_double) begin
            lo_word <= ram_word;
        end
    end

endmodule

// ==== design/data_ram.sv ====
`timescale 1ns/1ps
`include "mmio_settings.svh"

module data_ram (
    input  logic                          CLOCK_50,
    input  logic [$clog2(`RAM_WORDS)-1:0] ram_index,
    input  logic                          hi_word,
    input  logic                          write,
    input  mmio_pkg::bus_req_t            req,
    output logic [`WORD_WIDTH-1:0]        word
);
    import mmio_pkg::*;

    localparam int AW    = $clog2(`RAM_WORDS);
    localparam int LANES = `WORD_WIDTH / 8;

    logic [`WORD_WIDTH-1:0] mem [0:`RAM_WORDS-1];
    logic [AW-1:0]          index;
    logic [1:0]             offset;
    logic [LANES-1:0]       lane_en;
    logic [`WORD_WIDTH-1:0] wr_word;

    // second word of a double sits one index up
    assign index  = ram_index + AW'(hi_word);
    assign offset = req.addr[1:0];

    // replicate the store data so every lane sees its bytes
    always_comb begin
        case (req.ls_type)
            LS_B, LS_BU: begin
                lane_en = LANES'(1) << offset;
                wr_word = {LANES{req.wdata[7:0]}};
            end
            LS_H, LS_HU: begin
                // address bit 1 picks the half
                lane_en = offset[1] ? 4'b1100 : 4'b0011;
                wr_word = {2{req.wdata[15:0]}};
            end
            LS_D: begin
                lane_en = '1;
                wr_word = hi_word ? req.wdata[63:32] : req.wdata[31:0];
            end
            default: begin
                lane_en = '1;
                wr_word = req.wdata[`WORD_WIDTH-1:0];
            end
        endcase
    end

    // byte-lane store plus registered read, old data on a collision
    always_ff @(posedge CLOCK_50) begin
        if (write) begin
            for (int i = 0; i < LANES; i++) begin
                if (lane_en[i]) begin
                    mem[index][8*i +: 8] <= wr_word[8*i +: 8];
                end
            end
        end
        word <= mem[index];
    end

endmodule

// ==== design/key_interrupt.sv ====
`timescale 1ns/1ps

module key_interrupt (
    input  logic       CLOCK_50,
    input  logic       KEY0,
    input  logic [7:0] key_code,
    input  logic       key_pressed,
    input  logic       irq_ack,
    output logic [3:0] irq_vector
);

    logic key_valid;
    logic ack_seen;

    // a zero code is a release or filler, no interrupt for it
    assign key_valid = key_pressed && (key_code != 8'd0);
    // acknowledge only counts while a request is pending
    assign ack_seen  = irq_ack && (irq_vector != 4'd0);

    always_ff @(posedge CLOCK_50 or negedge KEY0) begin
        if (!KEY0) begin
            irq_vector <= 4'd0;
        end else if (ack_seen) begin
            // ack wins over a key press in the same cycle
            irq_vector <= 4'd0;
        end else if (key_valid) begin
            // keyboard owns vector 1
            irq_vector <= 4'd1;
        end
    end

endmodule

// ==== design/mmio_pkg.sv ====
`include "mmio_settings.svh"

package mmio_pkg;

    // load/store type as driven by the core
    typedef enum logic [2:0] {
        LS_B  = 3'd0,
        LS_H  = 3'd1,
        LS_W  = 3'd2,
        LS_D  = 3'd3,
        LS_BU = 3'd4,
        LS_HU = 3'd5,
        LS_WU = 3'd6
    } ls_type_e;

    // decoded target of a bus access
    typedef enum logic [2:0] {
        REGION_NONE,
        REGION_RAM,
        REGION_KEY,
        REGION_SD_ADDR,
        REGION_SD_READ,
        REGION_SD_READY,
        REGION_SD_AVAIL,
        REGION_SD_BUF
    } region_e;

    // bus sequencer states
    // the _HI states handle the upper word of a doubleword
    typedef enum logic [2:0] {
        ST_IDLE,
        ST_READ,
        ST_READ_HI,
        ST_WRITE,
        ST_WRITE_HI
    } seq_state_e;

    // one core-side request, held stable for the whole access
    typedef struct packed {
        logic [`ADDR_WIDTH-1:0] addr;
        logic [`DATA_WIDTH-1:0] wdata;
        ls_type_e               ls_type;
    } bus_req_t;

endpackage

// ==== design/mmio_settings.svh ====
`ifndef MMIO_SETTINGS_SVH
`define MMIO_SETTINGS_SVH

// core bus widths
`define ADDR_WIDTH 32
`define DATA_WIDTH 64
// ram is built from 32-bit words, doublewords take two of them
`define WORD_WIDTH 32

// on-chip data ram, 4 KiB starting at 0x1000
`define RAM_BASE  32'h0000_1000
`define RAM_WORDS 1024

// keyboard data register
`define KEY_ADDR 32'h0000_0F00

// sd bridge registers
`define SD_ADDR_REG  32'h0000_0F10
`define SD_READ_REG  32'h0000_0F14
`define SD_READY_REG 32'h0000_0F18
`define SD_AVAIL_REG 32'h0000_0F1C

// sector buffer window and capture limits
`define SD_BUF_BASE          32'h0000_0800
`define SD_SECTOR_BYTES      512
`define SD_AVAIL_CLEAR_INDEX 10

`endif

// ==== design/mmio_system.sv ====
`timescale 1ns/1ps
`include "mmio_settings.svh"

module mmio_system (
    input  logic                   CLOCK_50,
    input  logic                   KEY0,
    input  mmio_pkg::bus_req_t     bus_req,
    input  logic                   read_enable,
    input  logic                   write_enable,
    input  logic [7:0]             key_code,
    input  logic                   key_pressed,
    input  logic                   irq_ack,
    input  logic [7:0]             sd_byte,
    input  logic                   sd_byte_valid,
    input  logic                   sd_ready,
    output logic [`DATA_WIDTH-1:0] read_data,
    output logic                   read_done,
    output logic                   write_done,
    output logic [3:0]             irq_vector,
    output logic [31:0]            sd_sector,
    output logic                   sd_read_start
);
    import mmio_pkg::*;

    // decoder outputs
    region_e                              region;
    logic [$clog2(`RAM_WORDS)-1:0]        ram_index;
    logic [$clog2(`SD_SECTOR_BYTES)-1:0]  buf_index;
    // ram side
    logic [`WORD_WIDTH-1:0]               ram_word;
    logic                                 ram_write;
    logic                                 ram_hi_word;
    // register writes toward the sd bridge
    region_e                              reg_write;
    logic                                 reg_write_en;
    logic [7:0]                           buf_byte;
    logic                                 sd_available;

    address_decoder i_address_decoder (
        .addr      (bus_req.addr),
        .region    (region),
        .ram_index (ram_index),
        .buf_index (buf_index)
    );

    bus_sequencer i_bus_sequencer (
        .CLOCK_50     (CLOCK_50),
        .KEY0         (KEY0),
        .bus_req      (bus_req),
        .read_enable  (read_enable),
        .write_enable (write_enable),
        .region       (region),
        .ram_word     (ram_word),
        .key_code     (key_code),
        .sd_ready     (sd_ready),
        .sd_available (sd_available),
        .buf_byte     (buf_byte),
        .read_data    (read_data),
        .read_done    (read_done),
        .write_done   (write_done),
        .ram_write    (ram_write),
        .ram_hi_word  (ram_hi_word),
        .reg_write    (reg_write),
        .reg_write_en (reg_write_en)
    );

    data_ram i_data_ram (
        .CLOCK_50  (CLOCK_50),
        .ram_index (ram_index),
        .hi_word   (ram_hi_word),
        .write     (ram_write),
        .req       (bus_req),
        .word      (ram_word)
    );

    // sector address comes from the low word of the store data
    sd_sector_bridge i_sd_sector_bridge (
        .CLOCK_50      (CLOCK_50),
        .KEY0          (KEY0),
        .reg_write     (reg_write),
        .reg_write_en  (reg_write_en),
        .wdata         (bus_req.wdata[31:0]),
        .buf_index     (buf_index),
        .sd_byte       (sd_byte),
        .sd_byte_valid (sd_byte_valid),
        .buf_byte      (buf_byte),
        .sd_available  (sd_available),
        .sd_sector     (sd_sector),
        .sd_read_start (sd_read_start)
    );

    key_interrupt i_key_interrupt (
        .CLOCK_50    (CLOCK_50),
        .KEY0        (KEY0),
        .key_code    (key_code),
        .key_pressed (key_pressed),
        .irq_ack     (irq_ack),
        .irq_vector  (irq_vector)
    );

endmodule

// ==== design/sd_sector_bridge.sv ====
`timescale 1ns/1ps
`include "mmio_settings.svh"

module sd_sector_bridge (
    input  logic                                CLOCK_50,
    input  logic                                KEY0,
    input  mmio_pkg::region_e                   reg_write,
    input  logic                                reg_write_en,
    input  logic [31:0]                         wdata,
    input  logic [$clog2(`SD_SECTOR_BYTES)-1:0] buf_index,
    input  logic [7:0]                          sd_byte,
    input  logic                                sd_byte_valid,
    output logic [7:0]                          buf_byte,
    output logic                                sd_available,
    output logic [31:0]                         sd_sector,
    output logic                                sd_read_start
);
    import mmio_pkg::*;

    localparam int BW = $clog2(`SD_SECTOR_BYTES);
    // one extra bit so the index can sit at a full sector
    localparam int IW = BW + 1;

    logic [7:0]    buffer [0:`SD_SECTOR_BYTES-1];
    logic [IW-1:0] capture_index;
    logic          valid_d;
    logic          valid_rise;
    logic          sector_full;

    assign valid_rise  = sd_byte_valid && !valid_d;
    assign sector_full = capture_index == IW'(`SD_SECTOR_BYTES);

    always_ff @(posedge CLOCK_50 or negedge KEY0) begin
        if (!KEY0) begin
            valid_d       <= 1'b0;
            capture_index <= '0;
            sd_available  <= 1'b0;
            sd_sector     <= '0;
            sd_read_start <= 1'b0;
        end else begin
            valid_d <= sd_byte_valid;
            // read-start is a single-cycle pulse per register write
            sd_read_start <= reg_write_en && (reg_write == REGION_SD_READ);
            if (reg_write_en && (reg_write == REGION_SD_ADDR)) begin
                sd_sector <= wdata;
            end
            // wrap one cycle after the last byte and flag the sector
            if (sector_full) begin
                capture_index <= '0;
                sd_available  <= 1'b1;
            end else begin
                if (valid_rise) begin
                    capture_index <= capture_index + 1'b1;
                end
                // next sector is well under way, old data is stale
                if (capture_index == IW'(`SD_AVAIL_CLEAR_INDEX)) begin
                    sd_available <= 1'b0;
                end
            end
        end
    end

    // byte capture and registered read port
    always_ff @(posedge CLOCK_50) begin
        if (valid_rise && !sector_full) begin
            buffer[capture_index[BW-1:0]] <= sd_byte;
        end
        buf_byte <= buffer[buf_index];
    end

endmodule

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build and run the mmio_system testbench with Verilator.
# Exits non-zero when the build, the run or the final status check fails.

cd "$(dirname "$0")" || exit 1

LOG=sim.log
BIN=mmio_sim

verilator --binary --timing -Wno-fatal -f sources.f --top-module mmio_system_tb -o "$BIN"
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/"$BIN" > "$LOG" 2>&1
sim_status=$?
cat "$LOG"
if [ $sim_status -ne 0 ]; then
    echo "simulation exited with status $sim_status"
    exit 1
fi

if grep -q "^STATUS: PASS$" "$LOG"; then
    exit 0
fi
echo "pass message not found in $LOG"
exit 1

// ==== sources.f ====
+incdir+design
design/mmio_pkg.sv
design/address_decoder.sv
design/bus_sequencer.sv
design/data_ram.sv
design/sd_sector_bridge.sv
design/key_interrupt.sv
design/mmio_system.sv
verif/mmio_system_tb.sv

// ==== verif/mmio_system_tb.sv ====
`timescale 1ns/1ps
`include "mmio_settings.svh"

module mmio_system_tb;
    import mmio_pkg::*;

    localparam int RESET_CYCLES  = 3;
    localparam int ACCESS_LIMIT  = 8;
    // strobe setup plus the worst-case wait
    localparam int ACCESS_CYCLES = ACCESS_LIMIT + 2;
    localparam int STREAM_BYTES  = `SD_SECTOR_BYTES + `SD_AVAIL_CLEAR_INDEX;
    // cycle budget of each test
    localparam int RESET_BUDGET    = 4 + ACCESS_CYCLES;
    localparam int WORD_BUDGET     = 6 * ACCESS_CYCLES;
    localparam int SUB_WORD_BUDGET = 24 * ACCESS_CYCLES;
    localparam int KEY_BUDGET      = ACCESS_CYCLES + 20;
    localparam int SD_REG_BUDGET   = 4 * ACCESS_CYCLES + 8;
    localparam int STREAM_BUDGET   = 2 * STREAM_BYTES + (`SD_SECTOR_BYTES + 2) * ACCESS_CYCLES;
    localparam int UNMAPPED_BUDGET = 3 * ACCESS_CYCLES;
    localparam int CYCLE_LIMIT     = RESET_CYCLES + RESET_BUDGET + WORD_BUDGET +
                                     SUB_WORD_BUDGET + KEY_BUDGET + SD_REG_BUDGET +
                                     STREAM_BUDGET + UNMAPPED_BUDGET + 100;

    logic                   CLOCK_50;
    logic                   KEY0;
    bus_req_t               bus_req;
    logic                   read_enable;
    logic                   write_enable;
    logic [7:0]             key_code;
    logic                   key_pressed;
    logic                   irq_ack;
    logic [7:0]             sd_byte;
    logic                   sd_byte_valid;
    logic                   sd_ready;
    logic [`DATA_WIDTH-1:0] read_data;
    logic                   read_done;
    logic                   write_done;
    logic [3:0]             irq_vector;
    logic [31:0]            sd_sector;
    logic                   sd_read_start;

    integer seed;
    int     errors       = 0;
    int     tests_passed = 0;
    int     tests_failed = 0;
    int     cycle_count  = 0;
    int     start_pulses = 0;

    mmio_system i_mmio_system (
        .CLOCK_50      (CLOCK_50),
        .KEY0          (KEY0),
        .bus_req       (bus_req),
        .read_enable   (read_enable),
        .write_enable  (write_enable),
        .key_code      (key_code),
        .key_pressed   (key_pressed),
        .irq_ack       (irq_ack),
        .sd_byte       (sd_byte),
        .sd_byte_valid (sd_byte_valid),
        .sd_ready      (sd_ready),
        .read_data     (read_data),
        .read_done     (read_done),
        .write_done    (write_done),
        .irq_vector    (irq_vector),
        .sd_sector     (sd_sector),
        .sd_read_start (sd_read_start)
    );

    // 50 MHz clock
    initial begin
        CLOCK_50 = 1'b0;
        forever #10 CLOCK_50 = ~CLOCK_50;
    end

    // hard stop in case an access or a test never ends
    always @(posedge CLOCK_50) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= CYCLE_LIMIT) begin
            $display("ERROR: run did not finish within %0d cycles", CYCLE_LIMIT);
            $display("STATUS: FAIL");
            $finish;
        end
    end

    // one count per cycle that sd_read_start is high
    always @(negedge CLOCK_50) begin
        if (sd_read_start) begin
            start_pulses <= start_pulses + 1;
        end
    end

    task automatic check_data(input logic [`DATA_WIDTH-1:0] got,
                              input logic [`DATA_WIDTH-1:0] exp, input string msg);
        if (got !== exp) begin
            $display("MISMATCH at %0t: %s got %h expected %h", $time, msg, got, exp);
            errors++;
        end
    endtask

    task automatic check_irq(input logic [3:0] got, input logic [3:0] exp, input string msg);
        if (got !== exp) begin
            $display("MISMATCH at %0t: %s got %0d expected %0d", $time, msg, got, exp);
            errors++;
        end
    endtask

    task automatic check_flag(input logic got, input logic exp, input string msg);
        if (got !== exp) begin
            $display("MISMATCH at %0t: %s got %b expected %b", $time, msg, got, exp);
            errors++;
        end
    endtask

    task automatic check_sector(input logic [31:0] got, input logic [31:0] exp, input string msg);
        if (got !== exp) begin
            $display("MISMATCH at %0t: %s got %h expected %h", $time, msg, got, exp);
            errors++;
        end
    endtask

    function automatic bus_req_t build_req(input logic [`ADDR_WIDTH-1:0] addr,
                                           input logic [`DATA_WIDTH-1:0] wdata,
                                           input ls_type_e ls);
        bus_req_t req;
        req.addr    = addr;
        req.wdata   = wdata;
        req.ls_type = ls;
        return req;
    endfunction

    task automatic bus_read(input logic [`ADDR_WIDTH-1:0] addr, input ls_type_e ls,
                            output logic [`DATA_WIDTH-1:0] data);
        int waited;
        waited = 0;
        @(posedge CLOCK_50);
        bus_req     <= build_req(addr, '0, ls);
        read_enable <= 1'b1;
        @(posedge CLOCK_50);
        read_enable <= 1'b0;
        // done falls on the edge that samples the strobe
        @(negedge CLOCK_50);
        check_flag(read_done, 1'b0, "read_done after read strobe");
        waited = 1;
        while (!read_done && waited < ACCESS_LIMIT) begin
            @(negedge CLOCK_50);
            waited++;
        end
        if (!read_done) begin
            $display("ERROR: read of address %h did not complete within %0d cycles",
                     addr, ACCESS_LIMIT);
            errors++;
        end
        data = read_data;
    endtask

    task automatic bus_write(input logic [`ADDR_WIDTH-1:0] addr,
                             input logic [`DATA_WIDTH-1:0] wdata, input ls_type_e ls);
        int waited;
        waited = 0;
        @(posedge CLOCK_50);
        bus_req      <= build_req(addr, wdata, ls);
        write_enable <= 1'b1;
        @(posedge CLOCK_50);
        write_enable <= 1'b0;
        @(negedge CLOCK_50);
        check_flag(write_done, 1'b0, "write_done after write strobe");
        waited = 1;
        while (!write_done && waited < ACCESS_LIMIT) begin
            @(negedge CLOCK_50);
            waited++;
        end
        if (!write_done) begin
            $display("ERROR: write to address %h did not complete within %0d cycles",
                     addr, ACCESS_LIMIT);
            errors++;
        end
    endtask

    // one rising edge of byte-valid per byte
    task automatic send_byte(input logic [7:0] value);
        @(posedge CLOCK_50);
        sd_byte       <= value;
        sd_byte_valid <= 1'b1;
        @(posedge CLOCK_50);
        sd_byte_valid <= 1'b0;
    endtask

    task automatic report_test(input string name, input int errors_before);
        if (errors == errors_before) begin
            tests_passed++;
            $display("test %s: passed", name);
        end else begin
            tests_failed++;
            $display("test %s: failed with %0d errors", name, errors - errors_before);
        end
    endtask

    task automatic test_reset_state();
        logic [`DATA_WIDTH-1:0] data;
        int                     errors_before;
        errors_before = errors;
        @(negedge CLOCK_50);
        check_flag(read_done, 1'b1, "read_done after reset");
        check_flag(write_done, 1'b1, "write_done after reset");
        check_flag(sd_read_start, 1'b0, "sd_read_start after reset");
        check_irq(irq_vector, 4'd0, "irq_vector after reset");
        bus_read(`SD_AVAIL_REG, LS_W, data);
        check_data(data, 64'd0, "sd_available after reset");
        report_test("reset_state", errors_before);
    endtask

    task automatic test_ram_word_double();
        logic [31:0]            word_val;
        logic [63:0]            dword_val;
        logic [`DATA_WIDTH-1:0] data;
        int                     errors_before;
        errors_before = errors;
        word_val  = $random(seed);
        dword_val = {$random(seed), $random(seed)};
        // upper wdata bits of a word store are noise
        bus_write(`RAM_BASE + 32'h100, {32'($random(seed)), word_val}, LS_W);
        bus_read(`RAM_BASE + 32'h100, LS_W, data);
        check_data(data, {32'd0, word_val}, "LS_W read back");
        bus_write(`RAM_BASE + 32'h108, dword_val, LS_D);
        bus_read(`RAM_BASE + 32'h108, LS_D, data);
        check_data(data, dword_val, "LS_D read back");
        bus_read(`RAM_BASE + 32'h108, LS_W, data);
        check_data(data, {32'd0, dword_val[31:0]}, "low word of double");
        bus_read(`RAM_BASE + 32'h10C, LS_WU, data);
        check_data(data, {32'd0, dword_val[63:32]}, "high word of double");
        report_test("ram_word_double", errors_before);
    endtask

    task automatic test_ram_sub_word();
        logic [31:0]            addr;
        logic [31:0]            base;
        logic [31:0]            exp_word;
        logic [7:0]             b;
        logic [15:0]            h;
        logic [`DATA_WIDTH-1:0] data;
        int                     off;
        int                     errors_before;
        errors_before = errors;
        addr = `RAM_BASE + 32'h200;
        for (off = 0; off < 4; off++) begin
            base     = $random(seed);
            b        = 8'($random(seed));
            exp_word = base;
            exp_word[8*off +: 8] = b;
            bus_write(addr, {32'd0, base}, LS_W);
            bus_write(addr + 32'(off), {56'($random(seed)), b}, LS_B);
            bus_read(addr, LS_W, data);
            check_data(data, {32'd0, exp_word}, $sformatf("word after byte store %0d", off));
            // load comes back shifted and zero-extended
            bus_read(addr + 32'(off), LS_B, data);
            check_data(data, 64'(exp_word >> (8 * off)), $sformatf("byte load %0d", off));
        end
        for (off = 0; off < 4; off += 2) begin
            base     = $random(seed);
            h        = 16'($random(seed));
            exp_word = base;
            exp_word[8*off +: 16] = h;
            bus_write(addr, {32'd0, base}, LS_W);
            bus_write(addr + 32'(off), {48'($random(seed)), h}, LS_H);
            bus_read(addr, LS_W, data);
            check_data(data, {32'd0, exp_word}, $sformatf("word after half store %0d", off));
            bus_read(addr + 32'(off), LS_H, data);
            check_data(data, 64'(exp_word >> (8 * off)), $sformatf("half load %0d", off));
        end
        report_test("ram_sub_word", errors_before);
    endtask

    task automatic test_keyboard();
        logic [7:0]             code;
        logic [`DATA_WIDTH-1:0] data;
        int                     errors_before;
        errors_before = errors;
        code = 8'($random(seed)) | 8'h01;
        @(posedge CLOCK_50);
        key_code <= code;
        bus_read(`KEY_ADDR, LS_BU, data);
        check_data(data, {56'd0, code}, "keyboard data register");
        // zero code is ignored
        @(posedge CLOCK_50);
        key_code    <= 8'd0;
        key_pressed <= 1'b1;
        @(posedge CLOCK_50);
        key_pressed <= 1'b0;
        @(negedge CLOCK_50);
        check_irq(irq_vector, 4'd0, "press with zero code");
        @(posedge CLOCK_50);
        key_code    <= code;
        key_pressed <= 1'b1;
        @(posedge CLOCK_50);
        key_pressed <= 1'b0;
        @(negedge CLOCK_50);
        check_irq(irq_vector, 4'd1, "press with nonzero code");
        @(posedge CLOCK_50);
        irq_ack <= 1'b1;
        @(posedge CLOCK_50);
        irq_ack <= 1'b0;
        @(negedge CLOCK_50);
        check_irq(irq_vector, 4'd0, "after acknowledge");
        @(posedge CLOCK_50);
        key_pressed <= 1'b1;
        @(posedge CLOCK_50);
        key_pressed <= 1'b0;
        @(negedge CLOCK_50);
        check_irq(irq_vector, 4'd1, "second press");
        // acknowledge beats a press in the same cycle
        @(posedge CLOCK_50);
        key_pressed <= 1'b1;
        irq_ack     <= 1'b1;
        @(posedge CLOCK_50);
        key_pressed <= 1'b0;
        irq_ack     <= 1'b0;
        @(negedge CLOCK_50);
        check_irq(irq_vector, 4'd0, "press together with acknowledge");
        report_test("keyboard", errors_before);
    endtask

    task automatic test_sd_registers();
        logic [31:0]            sector;
        logic [`DATA_WIDTH-1:0] data;
        int                     pulses_before;
        int                     errors_before;
        errors_before = errors;
        sector = $random(seed);
        bus_write(`SD_ADDR_REG, {32'($random(seed)), sector}, LS_W);
        check_sector(sd_sector, sector, "sector address register");
        pulses_before = start_pulses;
        bus_write(`SD_READ_REG, 64'd1, LS_W);
        repeat (3) @(negedge CLOCK_50);
        check_flag(start_pulses == pulses_before + 1, 1'b1, "single sd_read_start pulse");
        @(posedge CLOCK_50);
        sd_ready <= 1'b1;
        bus_read(`SD_READY_REG, LS_W, data);
        check_data(data, 64'd1, "ready status high");
        @(posedge CLOCK_50);
        sd_ready <= 1'b0;
        bus_read(`SD_READY_REG, LS_W, data);
        check_data(data, 64'd0, "ready status low");
        report_test("sd_registers", errors_before);
    endtask

    task automatic test_sd_stream();
        logic [7:0]             sector_data [0:`SD_SECTOR_BYTES-1];
        logic [`DATA_WIDTH-1:0] data;
        int                     i;
        int                     errors_before;
        errors_before = errors;
        for (i = 0; i < `SD_SECTOR_BYTES; i++) begin
            sector_data[i] = 8'($random(seed));
        end
        for (i = 0; i < `SD_SECTOR_BYTES; i++) begin
            send_byte(sector_data[i]);
        end
        bus_read(`SD_AVAIL_REG, LS_W, data);
        check_data(data, 64'd1, "available after full sector");
        for (i = 0; i < `SD_SECTOR_BYTES; i++) begin
            bus_read(`SD_BUF_BASE + 32'(i), LS_BU, data);
            check_data(data, {56'd0, sector_data[i]}, $sformatf("buffer byte %0d", i));
        end
        // start of the next sector clears the flag
        for (i = 0; i < `SD_AVAIL_CLEAR_INDEX; i++) begin
            send_byte(8'($random(seed)));
        end
        bus_read(`SD_AVAIL_REG, LS_W, data);
        check_data(data, 64'd0, "available after next sector starts");
        report_test("sd_stream", errors_before);
    endtask

    task automatic test_unmapped();
        logic [`DATA_WIDTH-1:0] data;
        int                     errors_before;
        errors_before = errors;
        bus_write(32'h0000_3000, {$random(seed), $random(seed)}, LS_W);
        bus_read(32'h0000_3000, LS_D, data);
        check_data(data, 64'd0, "unmapped read above ram");
        bus_read(32'h0000_0400, LS_W, data);
        check_data(data, 64'd0, "unmapped read below registers");
        report_test("unmapped", errors_before);
    endtask

    initial begin
        seed          = 35;
        KEY0          = 1'b0;
        bus_req       = '0;
        read_enable   = 1'b0;
        write_enable  = 1'b0;
        key_code      = 8'd0;
        key_pressed   = 1'b0;
        irq_ack       = 1'b0;
        sd_byte       = 8'd0;
        sd_byte_valid = 1'b0;
        sd_ready      = 1'b0;
        repeat (RESET_CYCLES) @(posedge CLOCK_50);
        KEY0 <= 1'b1;

        test_reset_state();
        test_ram_word_double();
        test_ram_sub_word();
        test_keyboard();
        test_sd_registers();
        test_sd_stream();
        test_unmapped();

        $display("tests passed: %0d, tests failed: %0d", tests_passed, tests_failed);
        if (tests_failed == 0 && errors == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

endmodule
